// ==== csr_access_if.sv ====
`timescale 1ns/1ps

interface csr_access_if;

// one-cycle access strobe and its operands
logic                   valid;
logic                   we;
csr_op_pkg::csr_op_t    op;
logic                   uimm;
csr_map_pkg::csr_addr_t addr;
csr_op_pkg::csr_data_t  wdata;

// old register value, combinational during the strobe
csr_op_pkg::csr_data_t  rdata;

modport ctrl (
    output valid, we, op, uimm, addr, wdata,
    input  rdata
);

modport file (
    input  valid, we, op, uimm, addr, wdata,
    output rdata
);

endinterface

// ==== csr_consts.svh ====
`ifndef CSR_CONSTS_SVH
`define CSR_CONSTS_SVH

// ----------------------------------------------------------------------
// data path widths
// ----------------------------------------------------------------------

// one CSR data word
`define CSR_XLEN 32

// CSR address field
`define CSR_ADDR_W 12

// zero-extended immediate taken from the source low bits
`define CSR_UIMM_W 5

// cycle, instret and time counters
`define CSR_CNT_W 64

// default core clock, sets the microsecond divider
`define CSR_CLOCK_FREQ_HZ 250_000_000

`endif

// ==== csr_counter64.sv ====
`timescale 1ns/1ps
`include "csr_consts.svh"

module csr_counter64 (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   inc_i,
    input  logic                   wr_i,
    input  csr_map_pkg::csr_half_t half_i,
    input  csr_op_pkg::csr_data_t  wdata_i,
    output csr_op_pkg::csr_cnt_t   count_o
);

csr_op_pkg::csr_cnt_t cnt_next;

// ----------------------------------------------------------------------
// next value
// ----------------------------------------------------------------------
always_comb begin
    cnt_next = count_o;
    if (wr_i) begin
        // write wins, no increment this cycle
        cnt_next[half_i] = wdata_i;
    end else begin
        cnt_next = count_o + `CSR_CNT_W'(inc_i);
    end
end

always_ff @(posedge clk) begin
    if (rst) begin
        count_o <= '0;
    end else begin
        count_o <= cnt_next;
    end
end

endmodule

// ==== csr_file.sv ====
`timescale 1ns/1ps
`include "csr_consts.svh"

module csr_file #(
    parameter int unsigned CLOCK_FREQ_HZ = `CSR_CLOCK_FREQ_HZ
)(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  retire_i,
    csr_access_if.file            acc,
    output csr_op_pkg::csr_data_t tohost_o
);

localparam int unsigned CLOCKS_PER_US = CLOCK_FREQ_HZ / 1_000_000;
localparam int unsigned DIV_W = $clog2(CLOCKS_PER_US + 1);

csr_op_pkg::csr_data_t mscratch;
csr_op_pkg::csr_cnt_t mcycle, minstret, mtime;
csr_op_pkg::csr_data_t old_val, src_val, new_val;

// ----------------------------------------------------------------------
// read mux, old value of the addressed register
// ----------------------------------------------------------------------
always_comb begin
    case (acc.addr)
        csr_map_pkg::CSR_TOHOST: old_val = tohost_o;
        csr_map_pkg::CSR_MSCRATCH: old_val = mscratch;
        csr_map_pkg::CSR_MCYCLE: old_val = mcycle[csr_map_pkg::CSR_LOW];
        csr_map_pkg::CSR_MCYCLEH: old_val = mcycle[csr_map_pkg::CSR_HIGH];
        csr_map_pkg::CSR_MINSTRET: old_val = minstret[csr_map_pkg::CSR_LOW];
        csr_map_pkg::CSR_MINSTRETH: old_val = minstret[csr_map_pkg::CSR_HIGH];
        csr_map_pkg::CSR_TIME: old_val = mtime[csr_map_pkg::CSR_LOW];
        csr_map_pkg::CSR_TIMEH: old_val = mtime[csr_map_pkg::CSR_HIGH];
        default: old_val = '0;
    endcase
end
assign acc.rdata = old_val;

// immediate is zero-extended from the source low bits
assign src_val = acc.uimm ?
    {{(`CSR_XLEN-`CSR_UIMM_W){1'b0}}, acc.wdata[`CSR_UIMM_W-1:0]} : acc.wdata;

always_comb begin
    case (acc.op)
        csr_op_pkg::CSR_OP_RS: new_val = old_val | src_val;
        csr_op_pkg::CSR_OP_RC: new_val = old_val & ~src_val;
        default: new_val = src_val;
    endcase
end

// ----------------------------------------------------------------------
// address decode
// ----------------------------------------------------------------------
logic wr_en, sel_mcycle, sel_minstret;
csr_map_pkg::csr_half_t half;

assign wr_en = acc.valid && acc.we;
assign sel_mcycle = (acc.addr == csr_map_pkg::CSR_MCYCLE) ||
                    (acc.addr == csr_map_pkg::CSR_MCYCLEH);
assign sel_minstret = (acc.addr == csr_map_pkg::CSR_MINSTRET) ||
                      (acc.addr == csr_map_pkg::CSR_MINSTRETH);
assign half = ((acc.addr == csr_map_pkg::CSR_MCYCLEH) ||
               (acc.addr == csr_map_pkg::CSR_MINSTRETH)) ?
              csr_map_pkg::CSR_HIGH : csr_map_pkg::CSR_LOW;

// plain read/write registers
always_ff @(posedge clk) begin
    if (rst) begin
        tohost_o <= '0;
        mscratch <= '0;
    end else if (wr_en) begin
        if (acc.addr == csr_map_pkg::CSR_TOHOST) tohost_o <= new_val;
        if (acc.addr == csr_map_pkg::CSR_MSCRATCH) mscratch <= new_val;
    end
end

// microsecond tick, time steps one edge after the period ends
logic [DIV_W-1:0] cnt_us;
logic tick_us;
always_ff @(posedge clk) begin
    if (rst) begin
        cnt_us <= '0;
        tick_us <= 1'b0;
    end else if (cnt_us == DIV_W'(CLOCKS_PER_US - 1)) begin
        cnt_us <= '0;
        tick_us <= 1'b1;
    end else begin
        cnt_us <= cnt_us + 1'b1;
        tick_us <= 1'b0;
    end
end

// ----------------------------------------------------------------------
// counters
// ----------------------------------------------------------------------
csr_counter64 mcycle_i (
    .clk (clk), .rst (rst), .inc_i (1'b1), .wr_i (wr_en && sel_mcycle),
    .half_i (half), .wdata_i (new_val), .count_o (mcycle)
);

csr_counter64 minstret_i (
    .clk (clk), .rst (rst), .inc_i (retire_i), .wr_i (wr_en && sel_minstret),
    .half_i (half), .wdata_i (new_val), .count_o (minstret)
);

// read-only
csr_counter64 mtime_i (
    .clk (clk), .rst (rst), .inc_i (tick_us), .wr_i (1'b0),
    .half_i (csr_map_pkg::CSR_LOW), .wdata_i ('0), .count_o (mtime)
);

endmodule

// ==== csr_map_pkg.sv ====
`include "csr_consts.svh"

package csr_map_pkg;

// ----------------------------------------------------------------------
// register map
// ----------------------------------------------------------------------

// addresses decoded by the register file, anything else reads zero
typedef enum logic [`CSR_ADDR_W-1:0] {
    CSR_TOHOST    = 'h51E,
    CSR_MSCRATCH  = 'h340,
    CSR_MCYCLE    = 'hB00,
    CSR_MCYCLEH   = 'hB80,
    CSR_MINSTRET  = 'hB02,
    CSR_MINSTRETH = 'hB82,
    CSR_TIME      = 'hC01,
    CSR_TIMEH     = 'hC81
} csr_addr_t;

// word select inside a 64-bit counter
typedef enum logic {
    CSR_LOW  = 1'b0,
    CSR_HIGH = 1'b1
} csr_half_t;

endpackage

// ==== csr_op_pkg.sv ====
`include "csr_consts.svh"

package csr_op_pkg;

// ----------------------------------------------------------------------
// access types
// ----------------------------------------------------------------------

// single data word
typedef logic [`CSR_XLEN-1:0] csr_data_t;

// counter as low/high words, index 0 is the low word
typedef csr_data_t [`CSR_CNT_W/`CSR_XLEN-1:0] csr_cnt_t;

// same low bits as the funct3 encoding of csrrw/csrrs/csrrc
typedef enum logic [1:0] {
    CSR_OP_RW = 2'b01,
    CSR_OP_RS = 2'b10,
    CSR_OP_RC = 2'b11
} csr_op_t;

endpackage

// ==== csr_req_ctrl.sv ====
`timescale 1ns/1ps
`include "csr_consts.svh"

module csr_req_ctrl (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    req_i,
    output logic                    ack_o,
    input  csr_op_pkg::csr_op_t     op_i,
    input  logic                    uimm_i,
    input  logic                    we_i,
    input  logic [`CSR_ADDR_W-1:0]  addr_i,
    input  csr_op_pkg::csr_data_t   src_i,
    output csr_op_pkg::csr_data_t   rdata_o,
    csr_access_if.ctrl              acc
);

typedef enum logic {
    ST_IDLE,
    ST_ACKED
} state_t;

state_t state;
logic accept;

// new request only once the previous ack has dropped
assign accept = (state == ST_IDLE) && req_i && !ack_o;

// ----------------------------------------------------------------------
// handshake FSM
// ----------------------------------------------------------------------
always_ff @(posedge clk) begin
    if (rst) begin
        state <= ST_IDLE;
        acc.valid <= 1'b0;
        ack_o <= 1'b0;
        rdata_o <= '0;
    end else begin
        acc.valid <= accept;
        case (state)
            ST_IDLE: begin
                // ack falls the cycle after req low was seen
                ack_o <= 1'b0;
                if (accept) state <= ST_ACKED;
            end
            ST_ACKED: begin
                if (acc.valid) begin
                    ack_o <= 1'b1;
                    rdata_o <= acc.rdata;
                end
                if (ack_o && !req_i) state <= ST_IDLE;
            end
            default: state <= ST_IDLE;
        endcase
    end
end

// operands held for the strobe cycle
always_ff @(posedge clk) begin
    if (accept) begin
        acc.we <= we_i;
        acc.op <= op_i;
        acc.uimm <= uimm_i;
        acc.addr <= csr_map_pkg::csr_addr_t'(addr_i);
        acc.wdata <= src_i;
    end
end

endmodule

// ==== csr_unit_assertions.sv ====
`timescale 1ns/1ps
`include "csr_consts.svh"

module csr_unit_assertions (
    input logic                 clk,
    input logic                 rst,
    input logic                 req_i,
    input logic                 ack_i,
    input logic [`CSR_XLEN-1:0] tohost_i
);

// failures seen by the checks below
int fail_count = 0;

// ----------------------------------------------------------------------
// four-phase handshake
// ----------------------------------------------------------------------

// ack only answers a pending request
ack_rise_with_req: assert property (@(posedge clk) disable iff (rst)
    $rose(ack_i) |-> req_i)
    else begin
        $error("ack rose while req was low");
        fail_count++;
    end

// ack drops one cycle after req low was seen
ack_fall_after_req: assert property (@(posedge clk) disable iff (rst)
    $fell(ack_i) |-> !$past(req_i))
    else begin
        $error("ack fell before req went low");
        fail_count++;
    end

// tohost only moves with a completing access
tohost_stable: assert property (@(posedge clk) disable iff (rst)
    $changed(tohost_i) |-> $rose(ack_i))
    else begin
        $error("tohost changed outside an access");
        fail_count++;
    end

endmodule

bind csr_unit_top csr_unit_assertions csr_unit_assertions_i (
    .clk      (clk),
    .rst      (rst),
    .req_i    (req_i),
    .ack_i    (ack_o),
    .tohost_i (tohost_o)
);

// ==== csr_unit_top.sv ====
`timescale 1ns/1ps
`include "csr_consts.svh"

module csr_unit_top #(
    parameter int unsigned CLOCK_FREQ_HZ = `CSR_CLOCK_FREQ_HZ
)(
    input  logic                   clk,
    input  logic                   rst,
    // four-phase request
    input  logic                   req_i,
    output logic                   ack_o,
    input  csr_op_pkg::csr_op_t    op_i,
    input  logic                   uimm_i,
    input  logic                   we_i,
    input  logic [`CSR_ADDR_W-1:0] addr_i,
    input  csr_op_pkg::csr_data_t  src_i,
    output csr_op_pkg::csr_data_t  rdata_o,
    // core side
    input  logic                   retire_i,
    output csr_op_pkg::csr_data_t  tohost_o
);

csr_access_if acc ();

csr_req_ctrl csr_req_ctrl_i (
    .clk (clk),
    .rst (rst),
    .req_i (req_i),
    .ack_o (ack_o),
    .op_i (op_i),
    .uimm_i (uimm_i),
    .we_i (we_i),
    .addr_i (addr_i),
    .src_i (src_i),
    .rdata_o (rdata_o),
    .acc (acc.ctrl)
);

csr_file #(
    .CLOCK_FREQ_HZ (CLOCK_FREQ_HZ)
) csr_file_i (
    .clk (clk),
    .rst (rst),
    .retire_i (retire_i),
    .acc (acc.file),
    .tohost_o (tohost_o)
);

endmodule

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f tb.f --top-module tb_csr_unit -o tb_csr_unit
./obj_dir/tb_csr_unit

// ==== tb.f ====
+incdir+.
csr_map_pkg.sv
csr_op_pkg.sv
csr_access_if.sv
csr_req_ctrl.sv
csr_counter64.sv
csr_file.sv
csr_unit_top.sv
csr_unit_assertions.sv
tb_csr_unit.sv

// ==== tb_csr_unit.sv ====
`timescale 1ns/1ps
`include "csr_consts.svh"

module tb_csr_unit;

localparam int NUM_ROWS = 24;
localparam int WATCHDOG_CYCLES = 600;
localparam int CLOCKS_PER_US = `CSR_CLOCK_FREQ_HZ / 1_000_000;
localparam logic [15:0] LFSR_SEED = 16'd92;
localparam logic [15:0] LFSR_TAPS = 16'hB400;

// how a row's read data is judged
localparam logic [1:0] K_EXACT = 2'd0;
localparam logic [1:0] K_DELTA = 2'd1;
localparam logic [1:0] K_TIME = 2'd2;

localparam csr_op_pkg::csr_op_t OP_RW = csr_op_pkg::CSR_OP_RW;
localparam csr_op_pkg::csr_op_t OP_RS = csr_op_pkg::CSR_OP_RS;
localparam csr_op_pkg::csr_op_t OP_RC = csr_op_pkg::CSR_OP_RC;

typedef struct packed {
    csr_op_pkg::csr_op_t    op;
    logic                   uimm;
    logic                   we;
    logic [`CSR_ADDR_W-1:0] addr;
    logic [`CSR_XLEN-1:0]   src;
    logic [1:0]             kind;
    logic [9:0]             gap;
} row_t;

logic clk;
logic rst;
logic req;
logic ack;
csr_op_pkg::csr_op_t op;
logic uimm;
logic we;
logic [`CSR_ADDR_W-1:0] addr;
logic [`CSR_XLEN-1:0] src;
logic [`CSR_XLEN-1:0] rdata;
logic retire = 1'b0;
logic [`CSR_XLEN-1:0] tohost;

logic [15:0] lfsr = LFSR_SEED;
int cyc = 0;
int pulses = 0;
int last_ret = 0;

// op, uimm, we, address, source, kind, idle cycles before the access
row_t rows [NUM_ROWS] = '{
    '{OP_RW, 1'b0, 1'b1, csr_map_pkg::CSR_TOHOST, 32'hDEAD_BEEF, K_EXACT, 10'd0},
    '{OP_RW, 1'b0, 1'b1, csr_map_pkg::CSR_TOHOST, 32'h1234_5678, K_EXACT, 10'd0},
    '{OP_RW, 1'b0, 1'b1, csr_map_pkg::CSR_MSCRATCH, 32'hA5A5_0F0F, K_EXACT, 10'd0},
    '{OP_RS, 1'b0, 1'b1, csr_map_pkg::CSR_MSCRATCH, 32'h0000_F000, K_EXACT, 10'd0},
    '{OP_RC, 1'b0, 1'b1, csr_map_pkg::CSR_MSCRATCH, 32'h0000_000F, K_EXACT, 10'd2},
    '{OP_RS, 1'b1, 1'b1, csr_map_pkg::CSR_MSCRATCH, 32'hFFFF_FFF0, K_EXACT, 10'd0},
    '{OP_RC, 1'b1, 1'b1, csr_map_pkg::CSR_MSCRATCH, 32'h0000_0110, K_EXACT, 10'd0},
    '{OP_RS, 1'b0, 1'b0, csr_map_pkg::CSR_MSCRATCH, 32'hFFFF_FFFF, K_EXACT, 10'd0},
    '{OP_RW, 1'b0, 1'b0, csr_map_pkg::CSR_MSCRATCH, 32'h0000_0000, K_EXACT, 10'd0},
    // counters
    '{OP_RW, 1'b0, 1'b1, csr_map_pkg::CSR_MCYCLE, 32'h0000_1000, K_DELTA, 10'd0},
    '{OP_RS, 1'b0, 1'b0, csr_map_pkg::CSR_MCYCLE, 32'h0000_0000, K_DELTA, 10'd37},
    '{OP_RW, 1'b0, 1'b1, csr_map_pkg::CSR_MCYCLEH, 32'h0000_0002, K_DELTA, 10'd0},
    '{OP_RS, 1'b0, 1'b0, csr_map_pkg::CSR_MCYCLEH, 32'h0000_0000, K_DELTA, 10'd9},
    '{OP_RW, 1'b0, 1'b1, csr_map_pkg::CSR_MINSTRET, 32'h0000_0500, K_DELTA, 10'd0},
    '{OP_RS, 1'b0, 1'b0, csr_map_pkg::CSR_MINSTRET, 32'h0000_0000, K_DELTA, 10'd60},
    '{OP_RW, 1'b0, 1'b1, csr_map_pkg::CSR_MINSTRETH, 32'h0000_0001, K_DELTA, 10'd0},
    '{OP_RS, 1'b0, 1'b0, csr_map_pkg::CSR_MINSTRETH, 32'h0000_0000, K_DELTA, 10'd20},
    // time reads around a dropped write
    '{OP_RS, 1'b0, 1'b0, csr_map_pkg::CSR_TIME, 32'h0000_0000, K_TIME, 10'd0},
    '{OP_RW, 1'b0, 1'b1, csr_map_pkg::CSR_TIME, 32'hFFFF_FFFF, K_TIME, 10'd300},
    '{OP_RS, 1'b0, 1'b0, csr_map_pkg::CSR_TIME, 32'h0000_0000, K_TIME, 10'd480},
    '{OP_RS, 1'b0, 1'b0, csr_map_pkg::CSR_TIMEH, 32'h0000_0000, K_EXACT, 10'd0},
    // unmapped write followed by reads of its neighbours
    '{OP_RW, 1'b0, 1'b1, 12'h7C0, 32'hFFFF_FFFF, K_EXACT, 10'd0},
    '{OP_RS, 1'b0, 1'b0, csr_map_pkg::CSR_TOHOST, 32'h0000_0000, K_EXACT, 10'd0},
    '{OP_RS, 1'b0, 1'b0, csr_map_pkg::CSR_MSCRATCH, 32'h0000_0000, K_EXACT, 10'd0}
};

csr_unit_top csr_unit_i (
    .clk      (clk),
    .rst      (rst),
    .req_i    (req),
    .ack_o    (ack),
    .op_i     (op),
    .uimm_i   (uimm),
    .we_i     (we),
    .addr_i   (addr),
    .src_i    (src),
    .rdata_o  (rdata),
    .retire_i (retire),
    .tohost_o (tohost)
);

initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
end

function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    if (s[0]) return (s >> 1) ^ LFSR_TAPS;
    return s >> 1;
endfunction

function automatic logic [`CSR_XLEN-1:0] apply_op(input csr_op_pkg::csr_op_t o,
    input logic [`CSR_XLEN-1:0] old_v, input logic [`CSR_XLEN-1:0] src_v);
    case (o)
        csr_op_pkg::CSR_OP_RS: return old_v | src_v;
        csr_op_pkg::CSR_OP_RC: return old_v & ~src_v;
        default: return src_v;
    endcase
endfunction

task automatic check_value(input string name, input logic [`CSR_XLEN-1:0] got,
                           input logic [`CSR_XLEN-1:0] exp);
    if (got !== exp) begin
        $display("error: %s got 0x%08h expected 0x%08h", name, got, exp);
        $display("Test failed");
        $fatal(1, "%s mismatch", name);
    end
endtask

// ----------------------------------------------------------------------
// retire pulses and edge bookkeeping
// ----------------------------------------------------------------------
always @(posedge clk) begin
    if (rst) begin
        cyc <= 0;
        pulses <= 0;
        last_ret <= 0;
    end else begin
        cyc <= cyc + 1;
        pulses <= pulses + int'(retire);
        last_ret <= int'(retire);
    end
    retire <= lfsr[0];
    lfsr <= lfsr_step(lfsr);
end

// one four-phase access with snapshots taken just after ack rises
task automatic run_handshake(input row_t r, output logic [`CSR_XLEN-1:0] rd,
                             output int c, output int p, output int lr);
    @(posedge clk);
    req <= 1'b1;
    op <= r.op;
    uimm <= r.uimm;
    we <= r.we;
    addr <= r.addr;
    src <= r.src;
    do @(negedge clk); while (!ack);
    rd = rdata;
    c = cyc;
    p = pulses;
    lr = last_ret;
    @(posedge clk);
    req <= 1'b0;
    do @(negedge clk); while (ack);
endtask

initial begin
    repeat (NUM_ROWS * WATCHDOG_CYCLES) @(posedge clk);
    $display("Test failed");
    $fatal(1, "the run timed out before all accesses completed");
end

// ----------------------------------------------------------------------
// table walk against the register model
// ----------------------------------------------------------------------
initial begin
    row_t r;
    string name;
    logic [`CSR_XLEN-1:0] rd, srcv, old_val, new_val, delta, lo;
    logic [`CSR_XLEN-1:0] m_tohost, m_mscratch, t_ref_val;
    logic [`CSR_CNT_W-1:0] mc_val, mc_now, mi_val, mi_now;
    int c, p, lr, mc_ref, mi_ref, t_ref_cyc;

    rst <= 1'b1;
    req <= 1'b0;
    op <= csr_op_pkg::CSR_OP_RW;
    uimm <= 1'b0;
    we <= 1'b0;
    addr <= '0;
    src <= '0;
    m_tohost = '0;
    m_mscratch = '0;
    mc_val = '0;
    mi_val = '0;
    mc_ref = 0;
    mi_ref = 0;
    // time leaves zero one edge after the first full period
    t_ref_val = '0;
    t_ref_cyc = 2;
    repeat (5) @(posedge clk);
    rst <= 1'b0;

    for (int i = 0; i < NUM_ROWS; i++) begin
        r = rows[i];
        repeat (r.gap) @(posedge clk);
        run_handshake(r, rd, c, p, lr);
        srcv = r.uimm ? {{(`CSR_XLEN-`CSR_UIMM_W){1'b0}}, r.src[`CSR_UIMM_W-1:0]} : r.src;
        // counter values just before the access edge
        mc_now = mc_val + 64'(c - 1 - mc_ref);
        mi_now = mi_val + 64'(p - lr - mi_ref);
        case (r.addr)
            csr_map_pkg::CSR_TOHOST: old_val = m_tohost;
            csr_map_pkg::CSR_MSCRATCH: old_val = m_mscratch;
            csr_map_pkg::CSR_MCYCLE: old_val = mc_now[31:0];
            csr_map_pkg::CSR_MCYCLEH: old_val = mc_now[63:32];
            csr_map_pkg::CSR_MINSTRET: old_val = mi_now[31:0];
            csr_map_pkg::CSR_MINSTRETH: old_val = mi_now[63:32];
            // timeh stays zero over a short run and unmapped reads zero
            default: old_val = '0;
        endcase
        if (r.kind == K_TIME) begin
            delta = rd - t_ref_val;
            lo = 32'((c - t_ref_cyc) / CLOCKS_PER_US);
            // the spacing may straddle one extra tick
            if ((delta != lo) && (delta != lo + 1)) begin
                check_value("time delta", delta, lo);
            end
            t_ref_val = rd;
            t_ref_cyc = c;
        end else begin
            name = (r.kind == K_DELTA) ? "rdata_o (counter)" : "rdata_o";
            check_value(name, rd, old_val);
        end
        new_val = apply_op(r.op, old_val, srcv);
        if (r.we) begin
            case (r.addr)
                csr_map_pkg::CSR_TOHOST: m_tohost = new_val;
                csr_map_pkg::CSR_MSCRATCH: m_mscratch = new_val;
                csr_map_pkg::CSR_MCYCLE: mc_val = {mc_now[63:32], new_val};
                csr_map_pkg::CSR_MCYCLEH: mc_val = {new_val, mc_now[31:0]};
                csr_map_pkg::CSR_MINSTRET: mi_val = {mi_now[63:32], new_val};
                csr_map_pkg::CSR_MINSTRETH: mi_val = {new_val, mi_now[31:0]};
                default: ;
            endcase
            // a written counter restarts from the access edge
            if ((r.addr == csr_map_pkg::CSR_MCYCLE) || (r.addr == csr_map_pkg::CSR_MCYCLEH))
                mc_ref = c;
            if ((r.addr == csr_map_pkg::CSR_MINSTRET) || (r.addr == csr_map_pkg::CSR_MINSTRETH))
                mi_ref = p;
        end
        check_value("tohost_o", tohost, m_tohost);
    end

    if (csr_unit_i.csr_unit_assertions_i.fail_count != 0) begin
        $display("Test failed");
        $fatal(1, "%0d handshake or tohost assertions failed",
               csr_unit_i.csr_unit_assertions_i.fail_count);
    end else begin
        $display("Test completed successfully");
        $finish;
    end
end

endmodule
